/* compile.f */
src/pcie_phy_pkg.sv
src/os_csr_pkg.sv
src/os_symbol_framer.sv
src/ordered_set_handler.sv
src/os_status_csr.sv
src/os_rx_top.sv
testbench/tb_os_rx_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the os_rx_top testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_os_rx_top --Mdir obj_dir -o Vtb_os_rx_top
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_os_rx_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test failed" "$LOG"; then
  exit 1
fi
if ! grep -qx "test passed" "$LOG"; then
  echo "no pass line in $LOG"
  exit 1
fi
exit 0

/* testbench/tb_os_rx_top.sv */
`timescale 1ns/10ps

module tb_os_rx_top;

  localparam logic [31:0] SEED = 32'hbf07_e0ad;
  // worst-case cycles for all symbols with idle gaps and all AXI transactions
  localparam int N_SYMS      = 240;
  localparam int N_TXNS      = 45;
  localparam int TXN_CYC     = 10;
  localparam int WATCHDOG_NS = (3 * N_SYMS + TXN_CYC * N_TXNS) * 4 * 4;

  logic                          clk;
  logic                          rst;
  logic [7:0]                    sym;
  logic                          sym_k;
  logic                          sym_valid;
  logic [os_csr_pkg::ADDR_W-1:0] awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [31:0]                   wdata;
  logic [3:0]                    wstrb;
  logic                          wvalid;
  logic                          wready;
  logic [1:0]                    bresp;
  logic                          bvalid;
  logic                          bready;
  logic [os_csr_pkg::ADDR_W-1:0] araddr;
  logic                          arvalid;
  logic                          arready;
  logic [31:0]                   rdata;
  logic [1:0]                    rresp;
  logic                          rvalid;
  logic                          rready;

  // expected register state
  logic [1:0]  m_kind;
  logic [7:0]  m_link;
  logic [7:0]  m_lane;
  logic [7:0]  m_nfts;
  logic [7:0]  m_rate;
  logic [7:0]  m_ctrl;
  int          m_ts1;
  int          m_ts2;
  int          m_eieos;
  int          m_eios;
  int          errors;
  int          test_start_err;
  int          tests_ok;
  int          tests_bad;
  string       test_name;

  os_rx_top u_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .sym_i       (sym),
    .sym_k_i     (sym_k),
    .sym_valid_i (sym_valid),
    .awaddr_i    (awaddr),
    .awvalid_i   (awvalid),
    .awready_o   (awready),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .wvalid_i    (wvalid),
    .wready_o    (wready),
    .bresp_o     (bresp),
    .bvalid_o    (bvalid),
    .bready_i    (bready),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .arready_o   (arready),
    .rdata_o     (rdata),
    .rresp_o     (rresp),
    .rvalid_o    (rvalid),
    .rready_i    (rready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // read data must hold while the master stalls
  r_hold_chk: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $display("[ERROR] %0t read data changed under back-pressure", $time);
      errors++;
    end

  task automatic send_sym(input logic [7:0] s, input logic k);
    int gap;
    gap = $urandom_range(0, 2);
    repeat (gap) begin
      @(posedge clk);
      sym_valid <= 1'b0;
    end
    @(posedge clk);
    sym       <= s;
    sym_k     <= k;
    sym_valid <= 1'b1;
  endtask

  // lets the last set reach the registers 3 edges after symbol 15
  task automatic settle();
    @(posedge clk);
    sym_valid <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  // len below OS_LEN leaves the set unfinished, bad_idx spoils one identifier
  task automatic send_ts(input logic is_ts2, input int len, input int bad_idx);
    logic [7:0] fld [1:5];
    logic [7:0] id;
    id = is_ts2 ? pcie_phy_pkg::TS2_ID : pcie_phy_pkg::TS1_ID;
    for (int i = 1; i <= 5; i++) begin
      fld[i] = 8'($urandom);
    end
    for (int i = 0; i < len; i++) begin
      if (i == 0) begin
        send_sym(pcie_phy_pkg::SYM_COM, 1'b1);
      end else if (i <= 5) begin
        send_sym(fld[i], 1'b0);
      end else if (i == bad_idx) begin
        send_sym(8'h00, 1'b0);
      end else begin
        send_sym(id, 1'b0);
      end
    end
    if (len == pcie_phy_pkg::OS_LEN) begin
      if (bad_idx != 0) begin
        m_kind = pcie_phy_pkg::OS_NONE;
      end else begin
        m_kind = is_ts2 ? pcie_phy_pkg::OS_TS2 : pcie_phy_pkg::OS_TS1;
        m_link = fld[1];
        m_lane = fld[2];
        m_nfts = fld[3];
        m_rate = fld[4];
        m_ctrl = fld[5];
        if (is_ts2) begin
          m_ts2++;
        end else begin
          m_ts1++;
        end
      end
    end
  endtask

  task automatic send_eieos();
    send_sym(pcie_phy_pkg::SYM_COM, 1'b1);
    repeat (14) send_sym(pcie_phy_pkg::SYM_EIE, 1'b1);
    send_sym(pcie_phy_pkg::TS1_ID, 1'b0);
    m_kind = pcie_phy_pkg::OS_EIEOS;
    m_eieos++;
  endtask

  task automatic send_short_os(input logic [7:0] fill);
    send_sym(pcie_phy_pkg::SYM_COM, 1'b1);
    repeat (3) send_sym(fill, 1'b1);
  endtask

  task automatic expect_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input string what);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b0;
    do @(posedge clk); while (!awready);
    assert (wready) else begin
      $display("[ERROR] %0t %s: wready low while awready high", $time, what);
      errors++;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do @(posedge clk); while (!bvalid);
    bready <= 1'b0;
    assert (bresp == exp_resp) else begin
      $display("[ERROR] %0t %s: bresp %0d, expected %0d", $time, what, bresp, exp_resp);
      errors++;
    end
  endtask

  task automatic expect_read(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp, input string what);
    int hold;
    hold = $urandom_range(1, 3);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b0;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
    repeat (hold) @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
    assert (rdata == exp_data && rresp == exp_resp) else begin
      $display("[ERROR] %0t %s: read %h resp %0d, expected %h resp %0d",
               $time, what, rdata, rresp, exp_data, exp_resp);
      errors++;
    end
  endtask

  task automatic check_model();
    expect_read(os_csr_pkg::ADDR_LAST_TS, {m_rate, m_nfts, m_lane, m_link},
                os_csr_pkg::RESP_OKAY, "LAST_TS");
    expect_read(os_csr_pkg::ADDR_STATUS, {22'd0, m_kind, m_ctrl},
                os_csr_pkg::RESP_OKAY, "STATUS");
    expect_read(os_csr_pkg::ADDR_TS1_CNT, 32'(m_ts1), os_csr_pkg::RESP_OKAY, "TS1_CNT");
    expect_read(os_csr_pkg::ADDR_TS2_CNT, 32'(m_ts2), os_csr_pkg::RESP_OKAY, "TS2_CNT");
    expect_read(os_csr_pkg::ADDR_EI_CNT, {16'(m_eios), 16'(m_eieos)},
                os_csr_pkg::RESP_OKAY, "EI_CNT");
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_start_err = errors;
  endtask

  task automatic end_test();
    if (errors == test_start_err) begin
      tests_ok++;
      $display("[%0t] %s: ok", $time, test_name);
    end else begin
      tests_bad++;
      $display("[%0t] %s: bad, %0d errors", $time, test_name, errors - test_start_err);
    end
  endtask

  initial begin
    #WATCHDOG_NS;
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst       = 1'b1;
    sym       = 8'h00;
    sym_k     = 1'b0;
    sym_valid = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    m_kind    = pcie_phy_pkg::OS_NONE;
    m_link    = '0;
    m_lane    = '0;
    m_nfts    = '0;
    m_rate    = '0;
    m_ctrl    = '0;
    m_ts1     = 0;
    m_ts2     = 0;
    m_eieos   = 0;
    m_eios    = 0;
    errors    = 0;
    tests_ok  = 0;
    tests_bad = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    start_test("reset values");
    check_model();
    end_test();

    start_test("random training sets with SKP");
    for (int n = 0; n < 6; n++) begin
      // at least one SKP set always lands between two training sets
      if (n == 2 || $urandom_range(0, 1) == 1) begin
        send_short_os(pcie_phy_pkg::SYM_SKP);
      end
      send_ts(1'($urandom_range(0, 1)), pcie_phy_pkg::OS_LEN, 0);
    end
    settle();
    check_model();
    end_test();

    start_test("EIEOS and EIOS");
    send_eieos();
    settle();
    check_model();
    send_short_os(pcie_phy_pkg::SYM_IDL);
    m_eios++;
    settle();
    check_model();
    end_test();

    start_test("aborted and corrupt sets");
    // new COM lands at symbol 9 of the TS1
    send_ts(1'b0, 9, 0);
    send_ts(1'b1, pcie_phy_pkg::OS_LEN, 0);
    settle();
    check_model();
    send_ts(1'b0, pcie_phy_pkg::OS_LEN, 10);
    settle();
    check_model();
    end_test();

    start_test("counter clear and error responses");
    expect_write(os_csr_pkg::ADDR_CTRL, 32'h1, os_csr_pkg::RESP_OKAY, "CTRL clear");
    m_ts1   = 0;
    m_ts2   = 0;
    m_eieos = 0;
    m_eios  = 0;
    expect_write(os_csr_pkg::ADDR_TS1_CNT, 32'h5, os_csr_pkg::RESP_SLVERR, "TS1_CNT write");
    check_model();
    expect_read(8'h18, 32'h0, os_csr_pkg::RESP_SLVERR, "unmapped read");
    expect_read(os_csr_pkg::ADDR_CTRL, 32'h0, os_csr_pkg::RESP_SLVERR, "CTRL read");
    end_test();

    $display("tests ok: %0d, tests bad: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* src/os_rx_top.sv */
`timescale 1ns/10ps

module os_rx_top (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [7:0]                     sym_i,
  input  logic                           sym_k_i,
  input  logic                           sym_valid_i,
  input  logic [os_csr_pkg::ADDR_W-1:0]  awaddr_i,
  input  logic                           awvalid_i,
  output logic                           awready_o,
  input  logic [31:0]                    wdata_i,
  input  logic [3:0]                     wstrb_i,
  input  logic                           wvalid_i,
  output logic                           wready_o,
  output logic [1:0]                     bresp_o,
  output logic                           bvalid_o,
  input  logic                           bready_i,
  input  logic [os_csr_pkg::ADDR_W-1:0]  araddr_i,
  input  logic                           arvalid_i,
  output logic                           arready_o,
  output logic [31:0]                    rdata_o,
  output logic [1:0]                     rresp_o,
  output logic                           rvalid_o,
  input  logic                           rready_i
);

  logic [pcie_phy_pkg::OS_BITS-1:0]  os_data;
  logic [pcie_phy_pkg::OS_LEN-1:0]   os_k;
  logic                              os_valid;
  logic                              eios_seen;
  logic                              kind_valid;
  pcie_phy_pkg::os_kind_e            kind;
  logic [7:0]                        link_num;
  logic [7:0]                        lane_num;
  logic [7:0]                        n_fts;
  logic [7:0]                        rate_id;
  logic [7:0]                        train_ctrl;

  os_symbol_framer u_framer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sym_i       (sym_i),
    .sym_k_i     (sym_k_i),
    .sym_valid_i (sym_valid_i),
    .os_data_o   (os_data),
    .os_k_o      (os_k),
    .os_valid_o  (os_valid),
    .eios_o      (eios_seen)
  );

  ordered_set_handler u_handler (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .os_data_i    (os_data),
    .os_k_i       (os_k),
    .os_valid_i   (os_valid),
    .kind_o       (kind),
    .kind_valid_o (kind_valid),
    .link_num_o   (link_num),
    .lane_num_o   (lane_num),
    .nfts_o       (n_fts),
    .rate_id_o    (rate_id),
    .train_ctrl_o (train_ctrl)
  );

  os_status_csr u_csr (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .kind_i       (kind),
    .kind_valid_i (kind_valid),
    .eios_i       (eios_seen),
    .link_num_i   (link_num),
    .lane_num_i   (lane_num),
    .nfts_i       (n_fts),
    .rate_id_i    (rate_id),
    .train_ctrl_i (train_ctrl),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bresp_o      (bresp_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i)
  );

endmodule

/* src/os_status_csr.sv */
`timescale 1ns/10ps

module os_status_csr (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  pcie_phy_pkg::os_kind_e         kind_i,
  input  logic                           kind_valid_i,
  input  logic                           eios_i,
  input  logic [7:0]                     link_num_i,
  input  logic [7:0]                     lane_num_i,
  input  logic [7:0]                     nfts_i,
  input  logic [7:0]                     rate_id_i,
  input  logic [7:0]                     train_ctrl_i,
  input  logic [os_csr_pkg::ADDR_W-1:0]  awaddr_i,
  input  logic                           awvalid_i,
  output logic                           awready_o,
  input  logic [31:0]                    wdata_i,
  input  logic [3:0]                     wstrb_i,
  input  logic                           wvalid_i,
  output logic                           wready_o,
  output logic [1:0]                     bresp_o,
  output logic                           bvalid_o,
  input  logic                           bready_i,
  input  logic [os_csr_pkg::ADDR_W-1:0]  araddr_i,
  input  logic                           arvalid_i,
  output logic                           arready_o,
  output logic [31:0]                    rdata_o,
  output logic [1:0]                     rresp_o,
  output logic                           rvalid_o,
  input  logic                           rready_i
);

  pcie_phy_pkg::os_kind_e        last_kind;
  logic [7:0]                    last_link;
  logic [7:0]                    last_lane;
  logic [7:0]                    last_nfts;
  logic [7:0]                    last_rate;
  logic [7:0]                    last_ctrl;
  logic [os_csr_pkg::CNT_W-1:0]  ts1_cnt;
  logic [os_csr_pkg::CNT_W-1:0]  ts2_cnt;
  logic [os_csr_pkg::CNT_W-1:0]  eieos_cnt;
  logic [os_csr_pkg::CNT_W-1:0]  eios_cnt;
  logic                          wr_go;
  logic                          rd_go;
  logic                          wr_ctrl;
  logic                          clr;
  logic                          ts_seen;
  logic [31:0]                   rd_data_c;
  logic [1:0]                    rd_resp_c;

  function automatic logic [os_csr_pkg::CNT_W-1:0] sat_inc(
    input logic [os_csr_pkg::CNT_W-1:0] cnt
  );
    return (cnt == '1) ? cnt : cnt + 1'b1;
  endfunction

  // one write and one read in flight at most
  assign wr_go     = awvalid_i && wvalid_i && !bvalid_o;
  assign rd_go     = arvalid_i && !rvalid_o;
  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;
  assign wr_ctrl   = wr_go && (awaddr_i == os_csr_pkg::ADDR_CTRL);
  assign clr       = wr_ctrl && wstrb_i[0] && wdata_i[0];
  assign ts_seen   = kind_valid_i &&
                     (kind_i == pcie_phy_pkg::OS_TS1 || kind_i == pcie_phy_pkg::OS_TS2);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_kind <= pcie_phy_pkg::OS_NONE;
      last_link <= '0;
      last_lane <= '0;
      last_nfts <= '0;
      last_rate <= '0;
      last_ctrl <= '0;
    end else begin
      if (kind_valid_i) begin
        last_kind <= kind_i;
      end
      if (ts_seen) begin
        last_link <= link_num_i;
        last_lane <= lane_num_i;
        last_nfts <= nfts_i;
        last_rate <= rate_id_i;
        last_ctrl <= train_ctrl_i;
      end
    end
  end

  // clear wins over a same-cycle increment
  always_ff @(posedge clk_i) begin
    if (rst_i || clr) begin
      ts1_cnt   <= '0;
      ts2_cnt   <= '0;
      eieos_cnt <= '0;
      eios_cnt  <= '0;
    end else begin
      if (kind_valid_i && kind_i == pcie_phy_pkg::OS_TS1) begin
        ts1_cnt <= sat_inc(ts1_cnt);
      end
      if (kind_valid_i && kind_i == pcie_phy_pkg::OS_TS2) begin
        ts2_cnt <= sat_inc(ts2_cnt);
      end
      if (kind_valid_i && kind_i == pcie_phy_pkg::OS_EIEOS) begin
        eieos_cnt <= sat_inc(eieos_cnt);
      end
      if (eios_i) begin
        eios_cnt <= sat_inc(eios_cnt);
      end
    end
  end

  always_comb begin
    rd_resp_c = os_csr_pkg::RESP_OKAY;
    case (araddr_i)
      os_csr_pkg::ADDR_LAST_TS: rd_data_c = {last_rate, last_nfts, last_lane, last_link};
      os_csr_pkg::ADDR_STATUS:  rd_data_c = {22'd0, last_kind, last_ctrl};
      os_csr_pkg::ADDR_TS1_CNT: rd_data_c = {{(32-os_csr_pkg::CNT_W){1'b0}}, ts1_cnt};
      os_csr_pkg::ADDR_TS2_CNT: rd_data_c = {{(32-os_csr_pkg::CNT_W){1'b0}}, ts2_cnt};
      os_csr_pkg::ADDR_EI_CNT:  rd_data_c = {eios_cnt, eieos_cnt};
      default: begin
        // CTRL is write only
        rd_data_c = '0;
        rd_resp_c = os_csr_pkg::RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      if (wr_go) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_go) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      bresp_o <= wr_ctrl ? os_csr_pkg::RESP_OKAY : os_csr_pkg::RESP_SLVERR;
    end
    if (rd_go) begin
      rdata_o <= rd_data_c;
      rresp_o <= rd_resp_c;
    end
  end

  a_b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  a_r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

/* src/ordered_set_handler.sv */
`timescale 1ns/10ps

module ordered_set_handler (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [pcie_phy_pkg::OS_BITS-1:0]  os_data_i,
  input  logic [pcie_phy_pkg::OS_LEN-1:0]   os_k_i,
  input  logic                              os_valid_i,
  output pcie_phy_pkg::os_kind_e            kind_o,
  output logic                              kind_valid_o,
  output logic [7:0]                        link_num_o,
  output logic [7:0]                        lane_num_o,
  output logic [7:0]                        nfts_o,
  output logic [7:0]                        rate_id_o,
  output logic [7:0]                        train_ctrl_o
);

  pcie_phy_pkg::os_kind_e kind_c;
  logic                   is_ts_c;

  always_comb begin : classify
    logic ts1_hit;
    logic ts2_hit;
    logic eie_hit;
    ts1_hit = 1'b1;
    ts2_hit = 1'b1;
    eie_hit = 1'b1;
    // identifier symbols must be data, not k-codes
    for (int i = pcie_phy_pkg::ID_FIRST; i <= pcie_phy_pkg::ID_LAST; i++) begin
      if (os_k_i[i] || os_data_i[8*i +: 8] != pcie_phy_pkg::TS1_ID) begin
        ts1_hit = 1'b0;
      end
      if (os_k_i[i] || os_data_i[8*i +: 8] != pcie_phy_pkg::TS2_ID) begin
        ts2_hit = 1'b0;
      end
    end
    // EIEOS is COM, fourteen EIE, then a TS1 identifier
    for (int i = 1; i < pcie_phy_pkg::ID_LAST; i++) begin
      if (!os_k_i[i] || os_data_i[8*i +: 8] != pcie_phy_pkg::SYM_EIE) begin
        eie_hit = 1'b0;
      end
    end
    if (os_k_i[pcie_phy_pkg::ID_LAST] ||
        os_data_i[8*pcie_phy_pkg::ID_LAST +: 8] != pcie_phy_pkg::TS1_ID) begin
      eie_hit = 1'b0;
    end
    if (ts1_hit) begin
      kind_c = pcie_phy_pkg::OS_TS1;
    end else if (ts2_hit) begin
      kind_c = pcie_phy_pkg::OS_TS2;
    end else if (eie_hit) begin
      kind_c = pcie_phy_pkg::OS_EIEOS;
    end else begin
      kind_c = pcie_phy_pkg::OS_NONE;
    end
  end

  assign is_ts_c = (kind_c == pcie_phy_pkg::OS_TS1) || (kind_c == pcie_phy_pkg::OS_TS2);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      kind_valid_o <= 1'b0;
      kind_o       <= pcie_phy_pkg::OS_NONE;
    end else begin
      kind_valid_o <= os_valid_i;
      if (os_valid_i) begin
        kind_o <= kind_c;
      end
    end
  end

  // fields hold across EIEOS and unknown sets
  always_ff @(posedge clk_i) begin
    if (os_valid_i && is_ts_c) begin
      link_num_o   <= os_data_i[8*pcie_phy_pkg::BYTE_LINK +: 8];
      lane_num_o   <= os_data_i[8*pcie_phy_pkg::BYTE_LANE +: 8];
      nfts_o       <= os_data_i[8*pcie_phy_pkg::BYTE_NFTS +: 8];
      rate_id_o    <= os_data_i[8*pcie_phy_pkg::BYTE_RATE +: 8];
      train_ctrl_o <= os_data_i[8*pcie_phy_pkg::BYTE_CTRL +: 8];
    end
  end

  a_kind_follows: assert property (@(posedge clk_i) disable iff (rst_i)
    kind_valid_o == $past(os_valid_i));

endmodule

/* src/os_symbol_framer.sv */
`timescale 1ns/10ps

module os_symbol_framer (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [7:0]                         sym_i,
  input  logic                               sym_k_i,
  input  logic                               sym_valid_i,
  output logic [pcie_phy_pkg::OS_BITS-1:0]   os_data_o,
  output logic [pcie_phy_pkg::OS_LEN-1:0]    os_k_o,
  output logic                               os_valid_o,
  output logic                               eios_o
);

  typedef enum logic [2:0] {
    ST_HUNT,
    ST_FIRST,
    ST_COLLECT,
    ST_SKP,
    ST_EIOS
  } framer_state_e;

  framer_state_e state;
  // index of the next symbol, one bit wider than needed
  logic [4:0]    sym_cnt;
  logic          is_com;
  logic          is_skp;
  logic          is_idl;
  logic          bad_k;
  logic          wr_en;
  logic [3:0]    wr_idx;

  assign is_com = sym_k_i && (sym_i == pcie_phy_pkg::SYM_COM);
  assign is_skp = sym_k_i && (sym_i == pcie_phy_pkg::SYM_SKP);
  assign is_idl = sym_k_i && (sym_i == pcie_phy_pkg::SYM_IDL);
  // PAD and EIE are the only k-codes allowed inside a set
  assign bad_k  = sym_k_i && (sym_i != pcie_phy_pkg::SYM_PAD) &&
                  (sym_i != pcie_phy_pkg::SYM_EIE);

  // a COM always lands in slot 0, whatever the state
  always_comb begin
    wr_en  = 1'b0;
    wr_idx = sym_cnt[3:0];
    if (is_com) begin
      wr_en  = 1'b1;
      wr_idx = 4'd0;
    end else if ((state == ST_FIRST || state == ST_COLLECT) && !bad_k) begin
      wr_en = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sym_valid_i && wr_en) begin
      os_data_o[8*wr_idx +: 8] <= sym_i;
      os_k_o[wr_idx]           <= sym_k_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state      <= ST_HUNT;
      sym_cnt    <= '0;
      os_valid_o <= 1'b0;
      eios_o     <= 1'b0;
    end else begin
      os_valid_o <= 1'b0;
      eios_o     <= 1'b0;
      if (sym_valid_i) begin
        if (is_com) begin
          state   <= ST_FIRST;
          sym_cnt <= 5'd1;
        end else begin
          case (state)
            ST_FIRST: begin
              // symbol 1 picks the path
              if (is_skp) begin
                state   <= ST_SKP;
                sym_cnt <= 5'd2;
              end else if (is_idl) begin
                state   <= ST_EIOS;
                sym_cnt <= 5'd2;
              end else if (bad_k) begin
                state   <= ST_HUNT;
                sym_cnt <= '0;
              end else begin
                state   <= ST_COLLECT;
                sym_cnt <= 5'd2;
              end
            end
            ST_SKP: begin
              if (!is_skp || sym_cnt == 5'd3) begin
                state   <= ST_HUNT;
                sym_cnt <= '0;
              end else begin
                sym_cnt <= sym_cnt + 5'd1;
              end
            end
            ST_EIOS: begin
              if (!is_idl) begin
                state   <= ST_HUNT;
                sym_cnt <= '0;
              end else if (sym_cnt == 5'd3) begin
                eios_o  <= 1'b1;
                state   <= ST_HUNT;
                sym_cnt <= '0;
              end else begin
                sym_cnt <= sym_cnt + 5'd1;
              end
            end
            ST_COLLECT: begin
              if (bad_k) begin
                state   <= ST_HUNT;
                sym_cnt <= '0;
              end else if (sym_cnt == 5'(pcie_phy_pkg::OS_LEN - 1)) begin
                os_valid_o <= 1'b1;
                state      <= ST_HUNT;
                sym_cnt    <= '0;
              end else begin
                sym_cnt <= sym_cnt + 5'd1;
              end
            end
            default: begin
              sym_cnt <= '0;
            end
          endcase
        end
      end
    end
  end

  a_no_dual_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    !(os_valid_o && eios_o));

  a_cnt_range: assert property (@(posedge clk_i) disable iff (rst_i)
    sym_cnt <= 5'(pcie_phy_pkg::OS_LEN - 1));

endmodule

/* src/os_csr_pkg.sv */
package os_csr_pkg;

  localparam int ADDR_W = 8;

  // byte offsets of the status registers
  localparam logic [ADDR_W-1:0] ADDR_LAST_TS = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_STATUS  = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_TS1_CNT = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_TS2_CNT = 8'h0C;
  localparam logic [ADDR_W-1:0] ADDR_EI_CNT  = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_CTRL    = 8'h14;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // two counters share EI_CNT, so this is at most 16
  localparam int CNT_W = 16;

endpackage

/* src/pcie_phy_pkg.sv */
package pcie_phy_pkg;

  // 8b/10b k-codes, only meaningful with the k flag set
  localparam logic [7:0] SYM_COM = 8'hBC;
  localparam logic [7:0] SYM_SKP = 8'h1C;
  localparam logic [7:0] SYM_IDL = 8'h7C;
  localparam logic [7:0] SYM_EIE = 8'hFC;
  localparam logic [7:0] SYM_PAD = 8'hF7;

  // data identifiers, D10.2 and D5.2
  localparam logic [7:0] TS1_ID = 8'h4A;
  localparam logic [7:0] TS2_ID = 8'h45;

  // TS1, TS2 and EIEOS are all 16 symbols long
  localparam int OS_LEN  = 16;
  localparam int OS_BITS = OS_LEN * 8;

  // symbol positions inside a training set
  localparam int BYTE_LINK = 1;
  localparam int BYTE_LANE = 2;
  localparam int BYTE_NFTS = 3;
  localparam int BYTE_RATE = 4;
  localparam int BYTE_CTRL = 5;
  localparam int ID_FIRST  = 6;
  localparam int ID_LAST   = 15;

  // only the 8b/10b rates are handled here
  typedef enum logic {
    RATE_GEN1 = 1'b0,
    RATE_GEN2 = 1'b1
  } rate_e;

  // rate identifier symbol
  localparam int RATE_ID_GEN1_BIT  = 1;
  localparam int RATE_ID_GEN2_BIT  = 2;
  localparam int RATE_ID_SPD_CHG_BIT = 7;

  // training control symbol
  localparam int TC_HOT_RESET_BIT  = 0;
  localparam int TC_DIS_LINK_BIT   = 1;
  localparam int TC_LOOPBACK_BIT   = 2;
  localparam int TC_NO_SCRAMBLE_BIT = 3;

  // result of classifying a gathered set
  typedef enum logic [1:0] {
    OS_NONE  = 2'd0,
    OS_TS1   = 2'd1,
    OS_TS2   = 2'd2,
    OS_EIEOS = 2'd3
  } os_kind_e;

endpackage
